// File: bowlingScorer.f
rtl/bowlingPkg.sv
rtl/displayPkg.sv
rtl/rollDecoder.sv
rtl/bonusScorer.sv
rtl/scoreDisplay.sv
rtl/bowlingScorer.sv
verification/bowlingScorerTb.sv

// File: Bender.yml
package:
  name: bowlingScorer

sources:
  # packages first
  - rtl/bowlingPkg.sv
  - rtl/displayPkg.sv
  # design stages and top level
  - rtl/rollDecoder.sv
  - rtl/bonusScorer.sv
  - rtl/scoreDisplay.sv
  - rtl/bowlingScorer.sv
  # testbench
  - target: test
    files:
      - verification/bowlingScorerTb.sv

// File: verification/bowlingScorerTb.sv
// fixed games plus random games from seed 32'hc9f2; rolls on rising edges, checks on falling edges
`timescale 1ns/100ps
`default_nettype none

module bowlingScorerTb;
	import bowlingPkg::*;
	import displayPkg::*;

	localparam int ResetCycles = 5;
	localparam int PostRolls   = 3; // edges offered after the game has ended
	localparam int NumGames    = 15;
	// each game: up to 21 rolls, its reset, idle edges and one spare edge
	localparam int CycleLimit  = NumGames * (21 + ResetCycles + PostRolls + 1) + 50;

	localparam int ModeRandom    = 0;
	localparam int ModeStrikes   = 1;
	localparam int ModePerfect   = 2;
	localparam int ModeSpares    = 3;
	localparam int ModeOpen      = 4;
	localparam int ModeOverLimit = 5;

	logic  button;
	logic  arstN;
	pinsT  pointIn;
	scoreT pointAll;
	logic  gameOver;
	segT   hundred7SegCode;
	segT   ten7SegCode;
	segT   current7SegCode;

	int unsigned seed = 32'hc9f2;
	int rawRolls[$];     // as driven on pointIn
	int clampedRolls[$]; // as the rules count them
	int errorCount  = 0;
	int testCount   = 0;
	int failedTests = 0;
	int cycles      = 0;

	bowlingScorer UUT (
		.button          (button),
		.arstN           (arstN),
		.pointIn         (pointIn),
		.pointAll        (pointAll),
		.gameOver        (gameOver),
		.hundred7SegCode (hundred7SegCode),
		.ten7SegCode     (ten7SegCode),
		.current7SegCode (current7SegCode)
	);

	initial begin
		button = 1'b0;
		forever #20 button = ~button;
	end

	always @(posedge button) begin
		cycles = cycles + 1;
		if (cycles > CycleLimit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////
	// model
	////////////////////
	function automatic int unsigned nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed >> 16; // upper bits are the better ones
	endfunction

	function automatic int rollAt(input int k, input int count);
		return (k < count) ? clampedRolls[k] : 0; // unknown rolls count nothing yet
	endfunction

	// classic frame by frame score of the first count rolls
	function automatic int scoreRolls(input int count);
		int score;
		int idx;
		score = 0;
		idx   = 0;
		for (int frame = 1; frame <= 10; frame++) begin
			if (idx >= count)
				break;
			if (frame == 10) begin
				for (int k = idx; k < count; k++)
					score += clampedRolls[k]; // tenth frame at face value
				idx = count;
			end else if (clampedRolls[idx] == 10) begin
				score += 10 + rollAt(idx + 1, count) + rollAt(idx + 2, count);
				idx += 1;
			end else begin
				score += clampedRolls[idx] + rollAt(idx + 1, count);
				if (clampedRolls[idx] + rollAt(idx + 1, count) == 10)
					score += rollAt(idx + 2, count); // spare
				idx += 2;
			end
		end
		return score;
	endfunction

	function automatic segT segCode(input int digit);
		segT code;
		case (digit)
			0:       code = 7'b1111110;
			1:       code = 7'b0110000;
			2:       code = 7'b1101101;
			3:       code = 7'b1111001;
			4:       code = 7'b0110011;
			5:       code = 7'b1011011;
			6:       code = 7'b1011111;
			7:       code = 7'b1110000;
			8:       code = 7'b1111111;
			9:       code = 7'b1111011;
			default: code = 7'b0000000;
		endcase
		return code;
	endfunction

	function automatic int pickRaw(input int mode, input int standing, input int ball);
		int raw;
		case (mode)
			ModePerfect:   raw = 10;
			ModeSpares:    raw = (standing == 10) ? 5 : standing;
			ModeOpen:      raw = (ball == 0) ? 0 : 7; // gutter then seven
			ModeOverLimit: raw = (standing == 10) ? 5 : 9; // 9 after 5
			ModeStrikes:   raw = (nextRand() % 2 == 0) ? 15 : nextRand() % (standing + 1);
			default:       raw = (nextRand() % 8 == 0) ? nextRand() % 16 : nextRand() % (standing + 1);
		endcase
		return raw;
	endfunction

	task automatic buildGame(input int mode);
		int standing;
		int raw;
		int pins;
		int ball;
		int firstPins;
		bit more;
		rawRolls.delete();
		clampedRolls.delete();
		for (int frame = 1; frame <= 10; frame++) begin
			standing = 10;
			ball     = 0;
			more     = 1'b1;
			while (more) begin
				raw  = pickRaw(mode, standing, ball);
				pins = (raw > standing) ? standing : raw;
				rawRolls.push_back(raw);
				clampedRolls.push_back(pins);
				if (ball == 0)
					firstPins = pins;
				standing = standing - pins;
				if (frame < 10)
					more = (ball == 0) && (pins != 10);
				else if (ball == 0)
					more = 1'b1;
				else if (ball == 1)
					more = (firstPins == 10) || (firstPins + pins == 10); // fill ball earned
				else
					more = 1'b0;
				if (standing == 0)
					standing = 10; // fresh rack, tenth frame only
				ball++;
			end
		end
	endtask

	////////////////////
	// checks
	////////////////////
	task automatic checkOutputs(input int expTotal, input logic expOver);
		segT expHundreds;
		segT expTens;
		segT expUnits;
		expHundreds = segCode(expTotal / 100);
		expTens     = segCode((expTotal / 10) % 10);
		expUnits    = segCode(expTotal % 10);
		if (pointAll !== scoreT'(expTotal)) begin
			$display("** Error at %0t: pointAll expected %0d, got %0d", $time, expTotal, pointAll);
			errorCount++;
		end
		if (gameOver !== expOver) begin
			$display("** Error at %0t: gameOver expected %b, got %b", $time, expOver, gameOver);
			errorCount++;
		end
		if (hundred7SegCode !== expHundreds) begin
			$display("** Error at %0t: hundred7SegCode expected %b, got %b",
				$time, expHundreds, hundred7SegCode);
			errorCount++;
		end
		if (ten7SegCode !== expTens) begin
			$display("** Error at %0t: ten7SegCode expected %b, got %b", $time, expTens, ten7SegCode);
			errorCount++;
		end
		if (current7SegCode !== expUnits) begin
			$display("** Error at %0t: current7SegCode expected %b, got %b",
				$time, expUnits, current7SegCode);
			errorCount++;
		end
	endtask

	// starts and ends on a rising edge; abortAt > 0 resets after that many rolls
	task automatic runGame(input string name, input int mode, input int expRolls,
		input int expScore, input int abortAt);
		int errorsBefore;
		int lastIdx;
		int taken;
		bit done;
		errorsBefore = errorCount;
		buildGame(mode);
		arstN   <= 1'b0;
		pointIn <= '0;
		@(negedge button);
		checkOutputs(0, 1'b0);
		repeat (ResetCycles) @(posedge button);
		lastIdx = (abortAt > 0) ? abortAt : rawRolls.size() + PostRolls;
		for (int i = 0; i <= lastIdx; i++) begin
			if (i == 0)
				arstN <= 1'b1;
			// past the end of the game anything goes on pointIn
			pointIn <= (i < rawRolls.size()) ? pinsT'(rawRolls[i]) : pinsT'(nextRand() % 16);
			@(negedge button);
			done  = (i >= rawRolls.size());
			taken = done ? rawRolls.size() : i; // rolls the DUT has taken so far
			checkOutputs(scoreRolls(taken), done);
			@(posedge button);
		end
		if (abortAt > 0) begin
			arstN <= 1'b0; // mid-game reset
			@(negedge button);
			checkOutputs(0, 1'b0);
			@(posedge button);
		end
		if (expRolls >= 0 && rawRolls.size() != expRolls) begin
			$display("game took %0d rolls instead of %0d", rawRolls.size(), expRolls);
			errorCount++;
		end
		if (expScore >= 0 && scoreRolls(clampedRolls.size()) != expScore) begin
			$display("final score %0d differs from the expected %0d",
				scoreRolls(clampedRolls.size()), expScore);
			errorCount++;
		end
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("%-24s passed", name);
		end else begin
			$display("%-24s failed", name);
			failedTests++;
		end
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin
		arstN   = 1'b0;
		pointIn = '0;
		@(posedge button);
		runGame("perfect game", ModePerfect, 12, 300, 0);
		runGame("all spares", ModeSpares, 21, 150, 0);
		runGame("open frames", ModeOpen, 20, 70, 0);
		runGame("over-limit pins", ModeOverLimit, 21, 150, 0);
		runGame("mid-game reset", ModeRandom, -1, -1, 7);
		for (int g = 0; g < NumGames - 5; g++) begin
			if (g % 2 == 0)
				runGame($sformatf("random game %0d", g), ModeRandom, -1, -1, 0);
			else
				runGame($sformatf("strike heavy game %0d", g), ModeStrikes, -1, -1, 0);
		end
		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/bowlingScorer.sv
// single player scorer; one roll per rising button edge, total and display valid right after it
`timescale 1ns/100ps
`default_nettype none

module bowlingScorer (
	input  logic              button,
	input  logic              arstN,
	input  bowlingPkg::pinsT  pointIn,
	output bowlingPkg::scoreT pointAll,
	output logic              gameOver,
	output displayPkg::segT   hundred7SegCode,
	output displayPkg::segT   ten7SegCode,
	output displayPkg::segT   current7SegCode
);
	import bowlingPkg::*;
	import displayPkg::*;

	rollInfoT roll;   // decoded roll
	displayT  digits;

	rollDecoder decoder (
		.button   (button),
		.arstN    (arstN),
		.pointIn  (pointIn),
		.roll     (roll),
		.gameOver (gameOver)
	);

	bonusScorer scorer (
		.button (button),
		.arstN  (arstN),
		.roll   (roll),
		.total  (pointAll)
	);

	scoreDisplay display (
		.total  (pointAll),
		.digits (digits)
	);

	assign hundred7SegCode = digits.hundreds;
	assign ten7SegCode     = digits.tens;
	assign current7SegCode = digits.units; // units digit

endmodule

`default_nettype wire

// File: rtl/scoreDisplay.sv
// purely combinational; totals up to 511 split correctly, digits outside 0..9 show blank
`timescale 1ns/100ps
`default_nettype none

module scoreDisplay (
	input  bowlingPkg::scoreT    total,
	output displayPkg::displayT  digits
);
	import bowlingPkg::*;
	import displayPkg::*;

	scoreT rest;
	digitT hundreds;
	digitT tens;
	digitT units;

	// segment order a..g, active high
	function automatic segT toSeg(input digitT value);
		segT code;
		case (value)
			4'd0:    code = 7'b1111110;
			4'd1:    code = 7'b0110000;
			4'd2:    code = 7'b1101101;
			4'd3:    code = 7'b1111001;
			4'd4:    code = 7'b0110011;
			4'd5:    code = 7'b1011011;
			4'd6:    code = 7'b1011111;
			4'd7:    code = 7'b1110000;
			4'd8:    code = 7'b1111111;
			4'd9:    code = 7'b1111011;
			default: code = SegBlank;
		endcase
		return code;
	endfunction

	////////////////////
	// binary to decimal
	////////////////////
	always_comb begin
		rest     = total;
		hundreds = '0;
		tens     = '0;
		for (int i = 0; i < 5; i++) begin // 511 needs five hundreds at most
			if (rest >= scoreT'(100)) begin
				rest     = rest - scoreT'(100);
				hundreds = hundreds + digitT'(1);
			end
		end
		for (int i = 0; i < 9; i++) begin
			if (rest >= scoreT'(10)) begin
				rest = rest - scoreT'(10);
				tens = tens + digitT'(1);
			end
		end
		units = digitT'(rest); // below 10 by now
	end

	assign digits.hundreds = toSeg(hundreds);
	assign digits.tens     = toSeg(tens);
	assign digits.units    = toSeg(units);

endmodule

`default_nettype wire

// File: rtl/bonusScorer.sv
// total is updated on the same button edge as the roll; pins must arrive clamped from the decoder
`timescale 1ns/100ps
`default_nettype none

module bonusScorer (
	input  logic                 button,
	input  logic                 arstN,
	input  bowlingPkg::rollInfoT roll,
	output bowlingPkg::scoreT    total
);
	import bowlingPkg::*;

	bonusT nextBonus;  // bonuses riding on the next roll
	bonusT laterBonus; // bonuses riding on the roll after
	scoreT rollScore;

	// pins count once plus once per pending bonus
	always_comb begin
		rollScore = scoreT'(roll.pins) * (scoreT'(nextBonus) + scoreT'(1));
	end

	////////////////////
	// running total
	////////////////////
	always_ff @(posedge button or negedge arstN) begin
		if (!arstN) begin
			total      <= '0;
			nextBonus  <= '0;
			laterBonus <= '0;
		end else if (roll.valid) begin
			total      <= total + rollScore;
			// strike and spare both reach the next roll
			nextBonus  <= laterBonus + bonusT'(roll.addStrike | roll.addSpare);
			laterBonus <= bonusT'(roll.addStrike); // only a strike reaches two rolls ahead
		end
	end

endmodule

`default_nettype wire

// File: rtl/rollDecoder.sv
// button is the clock and must be debounced outside; pointIn is sampled on its rising edge
`timescale 1ns/100ps
`default_nettype none

module rollDecoder (
	input  logic                 button,
	input  logic                 arstN,
	input  bowlingPkg::pinsT     pointIn,
	output bowlingPkg::rollInfoT roll,
	output logic                 gameOver
);
	import bowlingPkg::*;

	ballStateT state;
	ballStateT nextState;
	frameT     frame;     // 1..10
	frameT     nextFrame;
	pinsT      standing;  // pins up for the coming ball
	pinsT      nextStanding;
	pinsT      pins;      // clamped count
	pinsT      rackLeft;  // what stays up after this ball
	logic      clear;     // ball takes all standing pins
	logic      prevClear; // previous ball took its whole rack
	logic      lastOpenFrame;

	////////////////////
	// classify roll
	////////////////////
	always_comb begin
		pins          = (pointIn > standing) ? standing : pointIn;
		clear         = (pins == standing);
		rackLeft      = clear ? pinsT'(MaxPins) : standing - pins; // fresh rack after a clear
		lastOpenFrame = (frame == frameT'(NumFrames - 1));

		roll       = '0;
		roll.valid = (state != gameDone);
		roll.pins  = roll.valid ? pins : '0;

		nextState    = state;
		nextFrame    = frame;
		nextStanding = rackLeft;

		case (state)
			firstBall: begin
				roll.addStrike = clear;
				if (clear) begin // strike ends the frame
					nextFrame = frame + frameT'(1);
					nextState = lastOpenFrame ? tenthFirst : firstBall;
				end else begin
					nextState = secondBall;
				end
			end
			secondBall: begin
				roll.addSpare = clear; // frame adds up to 10
				nextFrame     = frame + frameT'(1);
				nextState     = lastOpenFrame ? tenthFirst : firstBall;
				nextStanding  = pinsT'(MaxPins);
			end
			tenthFirst: begin
				nextState = tenthSecond;
			end
			tenthSecond: begin
				// a clear on the first ball was a strike
				roll.lastRoll = !(prevClear || clear);
				nextState     = roll.lastRoll ? gameDone : tenthFill;
			end
			tenthFill: begin
				roll.lastRoll = 1'b1;
				nextState     = gameDone;
			end
			default: begin
				nextState = gameDone; // also covers unused encodings
			end
		endcase
	end

	////////////////////
	// state registers
	////////////////////
	always_ff @(posedge button or negedge arstN) begin
		if (!arstN) begin
			state     <= firstBall;
			frame     <= frameT'(1);
			standing  <= pinsT'(MaxPins);
			prevClear <= 1'b0;
		end else if (roll.valid) begin
			state     <= nextState;
			frame     <= nextFrame;
			standing  <= nextStanding;
			prevClear <= clear;
		end
	end

	assign gameOver = (state == gameDone);

endmodule

`default_nettype wire

// File: rtl/displayPkg.sv
// segment codes are active high with segment a at index 0; common-anode boards need inverting
`default_nettype none

package displayPkg;

	////////////////////
	// segment types
	////////////////////

	// index 0 is segment a, index 6 is g
	typedef logic [0:6] segT;

	typedef logic [3:0] digitT; // one decimal digit

	localparam segT SegBlank = 7'b0000000; // all segments off

	// three digits of the score
	typedef struct packed {
		segT hundreds;
		segT tens;
		segT units;
	} displayT;

endpackage

`default_nettype wire

// File: rtl/bowlingPkg.sv
// game rules for one player only; pin counts above 10 are not legal rolls and get clamped upstream
`default_nettype none

package bowlingPkg;

	////////////////////
	// game rules
	////////////////////
	localparam int MaxPins   = 10;  // pins in a full rack
	localparam int NumFrames = 10;
	localparam int MaxScore  = 300; // perfect game

	////////////////////
	// widths
	////////////////////
	typedef logic [3:0] pinsT;  // 0..10 pins
	typedef logic [3:0] frameT; // frame 1..10

	// running total, sized to hold a perfect game
	typedef logic [$clog2(MaxScore + 1) - 1:0] scoreT;

	typedef logic [1:0] bonusT; // pending bonuses, 0..2

	////////////////////
	// decoder states
	////////////////////
	typedef enum logic [2:0] {
		firstBall,   // frames 1..9, first ball
		secondBall,  // frames 1..9, second ball
		tenthFirst,
		tenthSecond,
		tenthFill,   // bonus ball after strike or spare in frame 10
		gameDone
	} ballStateT;

	// one decoded roll, handed from decoder to scorer
	typedef struct packed {
		logic valid;     // roll counts
		pinsT pins;      // already clamped
		logic addStrike; // frames 1..9 only
		logic addSpare;  // frames 1..9 only
		logic lastRoll;  // ends the game
	} rollInfoT;

endpackage

`default_nettype wire
